//--- cache_bank_top.f
+incdir+hdl
hdl/cache_bank_pkg.sv
hdl/line_store.sv
hdl/init_sweep_counter.sv
hdl/bank_ctrl_fsm.sv
hdl/line_datapath.sv
hdl/cache_bank_top.sv
verification/cache_bank_tb.sv

//--- Bender.yml
package:
  name: cache_bank

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cache_bank_pkg.sv
      - hdl/line_store.sv
      - hdl/init_sweep_counter.sv
      - hdl/bank_ctrl_fsm.sv
      - hdl/line_datapath.sv
      - hdl/cache_bank_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/cache_bank_tb.sv

//--- verification/cache_bank_tb.sv
/*
 * Testbench for the cache bank. Sends reads and writes one at a time,
 * answers line reads from a memory model and checks every core response
 * and memory request against a cache model kept here.
 */

`include "cache_bank_defs.svh"

module cache_bank_tb;

    // 400 random requests at up to ~10 cycles, the directed tests and init
    localparam int CYCLE_LIMIT = 6000;
    localparam int MEM_LINES   = 1 << `CB_LINE_ADDR_W;

    logic                      clk;
    logic                      arst_n;
    logic                      core_req_valid;
    cache_bank_pkg::core_req_t core_req;
    logic                      ready;
    logic                      core_rsp_valid;
    cache_bank_pkg::core_rsp_t core_rsp;
    logic                      mem_req_valid;
    cache_bank_pkg::mem_req_t  mem_req;
    logic                      mem_rsp_valid;
    cache_bank_pkg::line_t     mem_rsp;

    // memory and cache models
    cache_bank_pkg::line_t      mem_model [MEM_LINES];
    logic                       cm_valid [`CB_NUM_LINES];
    logic [`CB_TAG_FIELD_W-1:0] cm_tag [`CB_NUM_LINES];
    cache_bank_pkg::line_t      cm_line [`CB_NUM_LINES];

    // outputs captured in the middle of the last cycle
    cache_bank_pkg::core_rsp_t smp_core_rsp;
    cache_bank_pkg::mem_req_t  smp_mem_req;

    integer seed;
    int     cycle_count;
    int     check_count;
    int     error_count;
    int     test_requests;
    int     test_errors_at_start;

    cache_bank_pkg::core_req_t written [$];

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= CYCLE_LIMIT);
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Verification failed");
        $finish;
    end

    cache_bank_top cache_bank_top_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .ready          (ready),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp        (mem_rsp)
    );

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic cache_bank_pkg::line_t random_line();
        cache_bank_pkg::line_t line;
        for (int w = 0; w < `CB_WORDS; w++) begin
            line[w] = rand32();
        end
        return line;
    endfunction

    function automatic logic [`CB_LINE_ADDR_W-1:0] make_addr(input int tag, input int idx);
        logic [`CB_LINE_ADDR_W-1:0] addr;
        addr = '0;
        addr[`CB_LINE_ADDR_W-1:`CB_INDEX_W] = tag[`CB_TAG_FIELD_W-1:0];
        addr[`CB_INDEX_W-1:0]               = idx[`CB_INDEX_W-1:0];
        return addr;
    endfunction

    function automatic cache_bank_pkg::core_req_t make_req(
        input logic [`CB_LINE_ADDR_W-1:0] line_addr,
        input logic                       rw
    );
        cache_bank_pkg::core_req_t req;
        logic [31:0]               r;
        r             = rand32();
        req.line_addr = line_addr;
        req.wsel      = r[1:0];
        req.rw        = rw;
        req.byteen    = r[5:2];
        req.tag       = r[9:6];
        req.data      = rand32();
        return req;
    endfunction

    function automatic logic [`CB_WORD_W-1:0] merge_bytes(
        input logic [`CB_WORD_W-1:0] old_word,
        input logic [`CB_WORD_W-1:0] new_word,
        input logic [`CB_BYTES-1:0]  byteen
    );
        logic [`CB_WORD_W-1:0] result;
        result = old_word;
        for (int b = 0; b < `CB_BYTES; b++) begin
            if (byteen[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    task automatic check_rsp(
        input cache_bank_pkg::core_rsp_t got,
        input cache_bank_pkg::core_rsp_t exp
    );
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH core_rsp: got data %h tag %h, expected data %h tag %h",
                     got.data, got.tag, exp.data, exp.tag);
        end
    endtask

    task automatic check_mem_req(
        input cache_bank_pkg::mem_req_t got,
        input cache_bank_pkg::mem_req_t exp
    );
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH mem_req: got rw %h addr %h wsel %h be %h data %h",
                     got.rw, got.line_addr, got.wsel, got.byteen, got.data);
            $display("MISMATCH mem_req: expected rw %h addr %h wsel %h be %h data %h",
                     exp.rw, exp.line_addr, exp.wsel, exp.byteen, exp.data);
        end
    endtask

    task automatic check_strobe(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            if (exp) begin
                $display("missing %s strobe in cycle %0d", name, cycle_count);
            end else begin
                $display("unexpected %s strobe in cycle %0d", name, cycle_count);
            end
        end
    endtask

    // sample mid-cycle, then drive idle inputs with junk fields after the edge
    task automatic step_cycle(input logic exp_rsp, input logic exp_mreq, input logic exp_ready);
        logic [31:0] r;
        @(negedge clk);
        check_strobe("core response", core_rsp_valid, exp_rsp);
        check_strobe("memory request", mem_req_valid, exp_mreq);
        check_count++;
        if (ready !== exp_ready) begin
            error_count++;
            $display("MISMATCH ready: got %h expected %h in cycle %0d",
                     ready, exp_ready, cycle_count);
        end
        smp_core_rsp = core_rsp;
        smp_mem_req  = mem_req;
        @(posedge clk);
        #1;
        r              = rand32();
        core_req_valid = 1'b0;
        core_req       = make_req(r[`CB_LINE_ADDR_W-1:0], r[31]);
        mem_rsp_valid  = 1'b0;
        mem_rsp        = random_line();
    endtask

    task automatic run_request(input cache_bank_pkg::core_req_t req);
        logic [`CB_INDEX_W-1:0]     idx;
        logic [`CB_TAG_FIELD_W-1:0] tag;
        logic                       hit;
        int                         delay;
        cache_bank_pkg::core_rsp_t  exp_rsp;
        cache_bank_pkg::mem_req_t   exp_mreq;
        cache_bank_pkg::mem_req_t   got_mreq;
        cache_bank_pkg::line_t      line;

        idx = req.line_addr[`CB_INDEX_W-1:0];
        tag = req.line_addr[`CB_LINE_ADDR_W-1:`CB_INDEX_W];
        hit = cm_valid[idx] && (cm_tag[idx] == tag);
        test_requests++;

        while (ready !== 1'b1) begin
            step_cycle(1'b0, 1'b0, 1'b0);
        end
        core_req_valid = 1'b1;
        core_req       = req;
        step_cycle(1'b0, 1'b0, 1'b1);
        step_cycle(1'b0, 1'b0, 1'b0);

        exp_rsp.tag = req.tag;
        if (req.rw) begin
            // a write goes through to memory and a miss allocates nothing
            step_cycle(1'b0, 1'b1, 1'b1);
            exp_mreq.rw        = 1'b1;
            exp_mreq.line_addr = req.line_addr;
            exp_mreq.wsel      = req.wsel;
            exp_mreq.byteen    = req.byteen;
            exp_mreq.data      = req.data;
            check_mem_req(smp_mem_req, exp_mreq);
            line            = mem_model[req.line_addr];
            line[req.wsel]  = merge_bytes(line[req.wsel], req.data, req.byteen);
            mem_model[req.line_addr] = line;
            if (hit) begin
                cm_line[idx][req.wsel] = merge_bytes(cm_line[idx][req.wsel], req.data,
                                                     req.byteen);
            end
        end else if (hit) begin
            step_cycle(1'b1, 1'b0, 1'b1);
            exp_rsp.data = cm_line[idx][req.wsel];
            check_rsp(smp_core_rsp, exp_rsp);
        end else begin
            step_cycle(1'b0, 1'b1, 1'b0);
            // a line read only needs rw and the line address
            exp_mreq           = '0;
            exp_mreq.line_addr = req.line_addr;
            got_mreq           = '0;
            got_mreq.rw        = smp_mem_req.rw;
            got_mreq.line_addr = smp_mem_req.line_addr;
            check_mem_req(got_mreq, exp_mreq);
            delay = 1 + (rand32() & 3);
            repeat (delay - 1) begin
                step_cycle(1'b0, 1'b0, 1'b0);
            end
            line          = mem_model[req.line_addr];
            mem_rsp_valid = 1'b1;
            mem_rsp       = line;
            step_cycle(1'b0, 1'b0, 1'b0);
            step_cycle(1'b1, 1'b0, 1'b1);
            exp_rsp.data = line[req.wsel];
            check_rsp(smp_core_rsp, exp_rsp);
            cm_valid[idx] = 1'b1;
            cm_tag[idx]   = tag;
            cm_line[idx]  = line;
        end
    endtask

    task automatic start_test();
        test_requests        = 0;
        test_errors_at_start = error_count;
    endtask

    task automatic report_test(input string name);
        $display("%s: %0d requests, %0d errors", name, test_requests,
                 error_count - test_errors_at_start);
    endtask

    initial begin
        cache_bank_pkg::core_req_t req;
        logic [31:0]               r;
        int                        init_cycles;

        seed           = 32'h5c3e;
        clk            = 1'b0;
        arst_n         = 1'b0;
        core_req_valid = 1'b0;
        core_req       = '0;
        mem_rsp_valid  = 1'b0;
        mem_rsp        = '0;
        check_count    = 0;
        error_count    = 0;
        for (int i = 0; i < MEM_LINES; i++) begin
            mem_model[i] = random_line();
        end
        for (int i = 0; i < `CB_NUM_LINES; i++) begin
            cm_valid[i] = 1'b0;
        end

        // init sweep, then a first read that must miss
        start_test();
        repeat (4) @(posedge clk);
        #1;
        check_count++;
        if (ready !== 1'b0 || core_rsp_valid !== 1'b0 || mem_req_valid !== 1'b0) begin
            error_count++;
            $display("ready or a strobe is not low during reset");
        end
        arst_n      = 1'b1;
        init_cycles = 0;
        while (ready !== 1'b1 && init_cycles <= 2 * `CB_NUM_LINES) begin
            step_cycle(1'b0, 1'b0, 1'b0);
            init_cycles++;
        end
        check_count++;
        if (init_cycles != `CB_NUM_LINES) begin
            error_count++;
            $display("ready went high after %0d init cycles instead of %0d",
                     init_cycles, `CB_NUM_LINES);
        end
        r = rand32();
        run_request(make_req(make_addr(0, r[3:0]), 1'b0));
        report_test("init");

        start_test();
        for (int i = 0; i < `CB_NUM_LINES; i++) begin
            run_request(make_req(make_addr(5, i), 1'b0));
        end
        report_test("read_miss");

        start_test();
        for (int i = 0; i < `CB_NUM_LINES; i++) begin
            run_request(make_req(make_addr(5, i), 1'b0));
        end
        report_test("read_hit");

        // tag 5 lines are cached, tag 9 lines are not
        start_test();
        for (int i = 0; i < `CB_NUM_LINES; i++) begin
            req = make_req(make_addr(5, i), 1'b1);
            written.push_back(req);
            run_request(req);
            req = make_req(make_addr(9, i), 1'b1);
            written.push_back(req);
            run_request(req);
        end
        foreach (written[k]) begin
            req    = written[k];
            req.rw = 1'b0;
            run_request(req);
        end
        report_test("write_through");

        // four tags per index keep lines being evicted and refilled
        start_test();
        repeat (400) begin
            r = rand32();
            run_request(make_req(make_addr(r[1:0], r[5:2]), r[6]));
            if (r[7]) begin
                step_cycle(1'b0, 1'b0, 1'b1);
            end
        end
        repeat (8) begin
            step_cycle(1'b0, 1'b0, 1'b1);
        end
        report_test("eviction");

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- hdl/cache_bank_top.sv
/*
 * Top level of a single blocking, direct-mapped, write-through cache bank.
 * The core strobes a request while ready is high; reads are answered on
 * core_rsp, writes and line reads go out on mem_req.
 */

`include "cache_bank_defs.svh"

module cache_bank_top (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      core_req_valid,
    input  cache_bank_pkg::core_req_t core_req,
    output logic                      ready,
    output logic                      core_rsp_valid,
    output cache_bank_pkg::core_rsp_t core_rsp,
    output logic                      mem_req_valid,
    output cache_bank_pkg::mem_req_t  mem_req,
    input  logic                      mem_rsp_valid,
    input  cache_bank_pkg::line_t     mem_rsp
);

    cache_bank_pkg::bank_state_t state;
    logic                        init_done;
    logic [`CB_INDEX_W-1:0]      init_index;
    logic                        hit;
    logic                        is_write;
    cache_bank_pkg::tag_entry_t  tag_rd;
    cache_bank_pkg::tag_entry_t  tag_wr;
    logic                        tag_wr_en;
    logic [`CB_INDEX_W-1:0]      tag_wr_index;
    cache_bank_pkg::line_t       data_rd;
    cache_bank_pkg::line_t       data_wr;
    logic                        data_wr_en;

    bank_ctrl_fsm ctrl_fsm (
        .clk            (clk),
        .arst_n         (arst_n),
        .core_req_valid (core_req_valid),
        .init_done      (init_done),
        .hit            (hit),
        .is_write       (is_write),
        .mem_rsp_valid  (mem_rsp_valid),
        .state          (state),
        .ready          (ready)
    );

    init_sweep_counter sweep (
        .clk    (clk),
        .arst_n (arst_n),
        .active (state == cache_bank_pkg::ST_INIT),
        .index  (init_index),
        .done   (init_done)
    );

    line_datapath datapath (
        .clk            (clk),
        .arst_n         (arst_n),
        .state          (state),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp        (mem_rsp),
        .init_index     (init_index),
        .tag_rd         (tag_rd),
        .data_rd        (data_rd),
        .tag_wr_en      (tag_wr_en),
        .tag_wr_index   (tag_wr_index),
        .tag_wr         (tag_wr),
        .data_wr_en     (data_wr_en),
        .data_wr        (data_wr),
        .hit            (hit),
        .is_write       (is_write),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req)
    );

    // both stores are read with the incoming request's index
    line_store #(.entry_t(cache_bank_pkg::tag_entry_t)) tag_store (
        .clk      (clk),
        .rd_index (core_req.line_addr[`CB_INDEX_W-1:0]),
        .rd_entry (tag_rd),
        .wr_en    (tag_wr_en),
        .wr_index (tag_wr_index),
        .wr_entry (tag_wr)
    );

    // data is written only outside init, when tag_wr_index is the request's
    line_store #(.entry_t(cache_bank_pkg::line_t)) data_store (
        .clk      (clk),
        .rd_index (core_req.line_addr[`CB_INDEX_W-1:0]),
        .rd_entry (data_rd),
        .wr_en    (data_wr_en),
        .wr_index (tag_wr_index),
        .wr_entry (data_wr)
    );

endmodule

//--- hdl/line_datapath.sv
/*
 * Datapath of the cache bank: request register, tag compare, word select,
 * byte merge for write hits, and the registered core response and memory
 * request. Store write controls are decoded from the FSM state.
 */

`include "cache_bank_defs.svh"

module line_datapath (
    input  logic                        clk,
    input  logic                        arst_n,
    input  cache_bank_pkg::bank_state_t state,
    input  logic                        core_req_valid,
    input  cache_bank_pkg::core_req_t   core_req,
    input  logic                        mem_rsp_valid,
    input  cache_bank_pkg::line_t       mem_rsp,
    input  logic [`CB_INDEX_W-1:0]      init_index,
    input  cache_bank_pkg::tag_entry_t  tag_rd,
    input  cache_bank_pkg::line_t       data_rd,
    output logic                        tag_wr_en,
    output logic [`CB_INDEX_W-1:0]      tag_wr_index,
    output cache_bank_pkg::tag_entry_t  tag_wr,
    output logic                        data_wr_en,
    output cache_bank_pkg::line_t       data_wr,
    output logic                        hit,
    output logic                        is_write,
    output logic                        core_rsp_valid,
    output cache_bank_pkg::core_rsp_t   core_rsp,
    output logic                        mem_req_valid,
    output cache_bank_pkg::mem_req_t    mem_req
);

    cache_bank_pkg::core_req_t req_q;
    cache_bank_pkg::line_t     merged_line;
    logic                      in_lookup;
    logic                      fill;
    logic                      rsp_load;
    logic                      mreq_load;

    always_ff @(posedge clk) begin
        if (core_req_valid && state == cache_bank_pkg::ST_IDLE) begin
            req_q <= core_req;
        end
    end

    assign in_lookup = (state == cache_bank_pkg::ST_LOOKUP);
    assign fill      = (state == cache_bank_pkg::ST_MISS_WAIT) && mem_rsp_valid;
    assign is_write  = req_q.rw;
    assign hit       = tag_rd.valid
                    && (tag_rd.tag == req_q.line_addr[`CB_LINE_ADDR_W-1:`CB_INDEX_W]);

    // write hit updates only the enabled bytes of the selected word
    always_comb begin
        merged_line = data_rd;
        for (int b = 0; b < `CB_BYTES; b++) begin
            if (req_q.byteen[b]) begin
                merged_line[req_q.wsel][b*8 +: 8] = req_q.data[b*8 +: 8];
            end
        end
    end

    // init clears tags, a fill sets a valid one
    assign tag_wr_en    = (state == cache_bank_pkg::ST_INIT) || fill;
    assign tag_wr_index = (state == cache_bank_pkg::ST_INIT) ? init_index
                                                           : req_q.line_addr[`CB_INDEX_W-1:0];
    assign tag_wr.valid = fill;
    assign tag_wr.tag   = req_q.line_addr[`CB_LINE_ADDR_W-1:`CB_INDEX_W];

    assign data_wr_en = fill || (in_lookup && is_write && hit);
    assign data_wr    = fill ? mem_rsp : merged_line;

    assign rsp_load  = (in_lookup && !is_write && hit) || fill;
    assign mreq_load = in_lookup && (is_write || !hit);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            core_rsp_valid <= 1'b0;
            mem_req_valid  <= 1'b0;
        end else begin
            core_rsp_valid <= rsp_load;
            mem_req_valid  <= mreq_load;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_load) begin
            core_rsp.data <= fill ? mem_rsp[req_q.wsel] : data_rd[req_q.wsel];
            core_rsp.tag  <= req_q.tag;
        end
        if (mreq_load) begin
            mem_req.rw        <= req_q.rw;
            mem_req.line_addr <= req_q.line_addr;
            mem_req.wsel      <= req_q.wsel;
            mem_req.byteen    <= req_q.byteen;
            mem_req.data      <= req_q.data;
        end
    end

endmodule

//--- hdl/bank_ctrl_fsm.sv
/*
 * Control FSM of the blocking cache bank. Sequences the init sweep,
 * the tag lookup and the wait for a line fill on a read miss.
 * Ready is a level that is high only while the bank is idle.
 */

module bank_ctrl_fsm (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       core_req_valid,
    input  logic                       init_done,
    input  logic                       hit,
    input  logic                       is_write,
    input  logic                       mem_rsp_valid,
    output cache_bank_pkg::bank_state_t state,
    output logic                       ready
);

    cache_bank_pkg::bank_state_t state_next;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= cache_bank_pkg::ST_INIT;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            cache_bank_pkg::ST_INIT: begin
                // hold until every tag has been invalidated
                if (init_done) begin
                    state_next = cache_bank_pkg::ST_IDLE;
                end
            end

            cache_bank_pkg::ST_IDLE: begin
                if (core_req_valid) begin
                    state_next = cache_bank_pkg::ST_LOOKUP;
                end
            end

            cache_bank_pkg::ST_LOOKUP: begin
                // writes never allocate, so only a read miss waits
                if (hit || is_write) begin
                    state_next = cache_bank_pkg::ST_IDLE;
                end else begin
                    state_next = cache_bank_pkg::ST_MISS_WAIT;
                end
            end

            cache_bank_pkg::ST_MISS_WAIT: begin
                if (mem_rsp_valid) begin
                    state_next = cache_bank_pkg::ST_IDLE;
                end
            end

            default: begin
                state_next = cache_bank_pkg::ST_INIT;
            end
        endcase
    end

    // one request in flight at a time
    assign ready = (state == cache_bank_pkg::ST_IDLE);

endmodule

//--- hdl/init_sweep_counter.sv
/*
 * Walks every line index once after reset so the tag array can be cleared.
 * Counts while active is high; done marks the last index of the sweep.
 */

`include "cache_bank_defs.svh"

module init_sweep_counter (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   active,
    output logic [`CB_INDEX_W-1:0] index,
    output logic                   done
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            index <= '0;
        end else if (active) begin
            index <= index + 1'b1;
        end
    end

    // last line gets its invalid write in this cycle
    assign done = active && (index == `CB_INDEX_W'(`CB_NUM_LINES - 1));

endmodule

//--- hdl/line_store.sv
/*
 * Per-line storage array with one registered read port and one write port.
 * Instantiated once for tag entries and once for data lines.
 */

`include "cache_bank_defs.svh"

module line_store #(
    parameter type entry_t = logic
) (
    input  logic                   clk,
    input  logic [`CB_INDEX_W-1:0] rd_index,
    output entry_t                 rd_entry,
    input  logic                   wr_en,
    input  logic [`CB_INDEX_W-1:0] wr_index,
    input  entry_t                 wr_entry
);

    entry_t mem [`CB_NUM_LINES];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_index] <= wr_entry;
        end
    end

    // read data follows the address by one cycle
    always_ff @(posedge clk) begin
        rd_entry <= mem[rd_index];
    end

endmodule

//--- hdl/cache_bank_pkg.sv
/*
 * Shared types of the cache bank: core and memory request/response
 * structs, the line and tag entry layouts, and the bank state encoding.
 */

`include "cache_bank_defs.svh"

package cache_bank_pkg;

    typedef struct packed {
        logic [`CB_LINE_ADDR_W-1:0] line_addr;
        logic [`CB_WSEL_W-1:0]      wsel;
        logic                       rw;
        logic [`CB_BYTES-1:0]       byteen;
        logic [`CB_WORD_W-1:0]      data;
        logic [`CB_REQ_TAG_W-1:0]   tag;
    } core_req_t;

    typedef struct packed {
        logic [`CB_WORD_W-1:0]    data;
        logic [`CB_REQ_TAG_W-1:0] tag;
    } core_rsp_t;

    typedef struct packed {
        logic                       rw;
        logic [`CB_LINE_ADDR_W-1:0] line_addr;
        logic [`CB_WSEL_W-1:0]      wsel;
        logic [`CB_BYTES-1:0]       byteen;
        logic [`CB_WORD_W-1:0]      data;
    } mem_req_t;

    // also the payload of a memory response
    typedef logic [`CB_WORDS-1:0][`CB_WORD_W-1:0] line_t;

    typedef struct packed {
        logic                       valid;
        logic [`CB_TAG_FIELD_W-1:0] tag;
    } tag_entry_t;

    typedef enum logic [1:0] {
        ST_INIT,
        ST_IDLE,
        ST_LOOKUP,
        ST_MISS_WAIT
    } bank_state_t;

endpackage

//--- hdl/cache_bank_defs.svh
/*
 * Size definitions for the direct-mapped write-through cache bank.
 * Included by the package and by every module that needs an index or width.
 */

`ifndef CACHE_BANK_DEFS_SVH
`define CACHE_BANK_DEFS_SVH

// line address splits into tag field and index
`define CB_LINE_ADDR_W 10
`define CB_INDEX_W     4
`define CB_NUM_LINES   16
`define CB_TAG_FIELD_W (`CB_LINE_ADDR_W - `CB_INDEX_W)

// line layout
`define CB_WORDS       4
`define CB_WSEL_W      2
`define CB_WORD_W      32
`define CB_BYTES       4

// core request tag, echoed back in the response
`define CB_REQ_TAG_W   4

`endif
